//--- rtl/ifetch_pkg.sv
`default_nettype none

package ifetch_pkg;

  // ***********************************************************
  // Datapath and L1 instruction cache geometry
  // ***********************************************************

  localparam int XLEN = 32;

  localparam int L1I_SETS  = 4;   // Direct mapped, one line per set
  localparam int L1I_WORDS = 2;   // Words per line
  localparam int IDX_W     = 2;
  localparam int OFF_W     = 1;
  localparam int TAG_W     = XLEN - IDX_W - OFF_W - 2;

  localparam int QUEUE_DEPTH = 4;

  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0000;

  // ***********************************************************
  // RV32I major opcodes used by fetch and retire
  // ***********************************************************

  localparam logic [6:0] OP_LUI      = 7'b0110111;
  localparam logic [6:0] OP_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM   = 7'b1110011;

  // fence.i with all other fields zero
  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100F;

  // ***********************************************************
  // Queue entry
  // ***********************************************************

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } fetch_entry_t;

endpackage

`default_nettype wire

//--- rtl/icache_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module icache_fetch (
  input  wire                          clk,
  input  wire                          rst,
  // Instruction bus
  output logic [ifetch_pkg::XLEN-1:0]  ifu_araddr_o,
  output logic                         ifu_arvalid_o,
  input  wire  [ifetch_pkg::XLEN-1:0]  ifu_rdata_i,
  input  wire                          ifu_rvalid_i,
  // Resolved next PC from retire
  input  wire  [ifetch_pkg::XLEN-1:0]  npc_i,
  input  wire                          npc_valid_i,
  // To instruction queue
  output logic [ifetch_pkg::XLEN-1:0]  fetch_pc_o,
  output logic [ifetch_pkg::XLEN-1:0]  fetch_inst_o,
  output logic                         fetch_valid_o,
  input  wire                          enq_ready_i
);
  import ifetch_pkg::*;

  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_EVEN_REQ,
    FILL_EVEN_DONE,
    FILL_ODD_REQ
  } fill_state_t;

  fill_state_t fill_state;
  logic [XLEN-1:0] pc_q;
  logic branch_stall_q;   // Waiting for the resolved next PC

  logic [L1I_SETS-1:0] line_valid;
  logic [TAG_W-1:0] line_tag [L1I_SETS];
  logic [XLEN-1:0] line_data [L1I_SETS][L1I_WORDS];

  logic [TAG_W-1:0] pc_tag;
  logic [IDX_W-1:0] pc_idx;
  logic [OFF_W-1:0] pc_off;
  logic line_hit;
  logic [6:0] opcode;
  logic is_ctrl;
  logic is_fence_i;
  logic emit;

  assign pc_tag = pc_q[XLEN-1 -: TAG_W];
  assign pc_idx = pc_q[OFF_W+2 +: IDX_W];
  assign pc_off = pc_q[2 +: OFF_W];

  assign line_hit = line_valid[pc_idx] && (line_tag[pc_idx] == pc_tag);

  assign fetch_pc_o    = pc_q;
  assign fetch_inst_o  = line_data[pc_idx][pc_off];
  assign fetch_valid_o = line_hit && !branch_stall_q;

  assign opcode     = fetch_inst_o[6:0];
  assign is_ctrl    = (opcode == OP_JAL) || (opcode == OP_JALR) || (opcode == OP_BRANCH);
  assign is_fence_i = (fetch_inst_o == INST_FENCE_I);
  assign emit       = fetch_valid_o && enq_ready_i;

  // ***********************************************************
  // Line fill, even word first
  // ***********************************************************

  assign ifu_arvalid_o = (fill_state == FILL_EVEN_REQ) || (fill_state == FILL_ODD_REQ);
  assign ifu_araddr_o  = {pc_q[XLEN-1:OFF_W+2], OFF_W'(fill_state == FILL_ODD_REQ), 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_state     <= FILL_IDLE;
      line_valid     <= '0;
      pc_q           <= PC_INIT;
      branch_stall_q <= 1'b0;
    end else begin
      case (fill_state)
        FILL_IDLE: begin
          if (!line_hit && !branch_stall_q) begin
            fill_state         <= FILL_EVEN_REQ;
            line_valid[pc_idx] <= 1'b0;   // Old line is being replaced
          end
        end
        FILL_EVEN_REQ: begin
          if (ifu_rvalid_i) begin
            fill_state <= FILL_EVEN_DONE;
          end
        end
        FILL_EVEN_DONE: begin
          fill_state <= FILL_ODD_REQ;   // One idle bus cycle between the reads
        end
        FILL_ODD_REQ: begin
          if (ifu_rvalid_i) begin
            fill_state         <= FILL_IDLE;
            line_valid[pc_idx] <= 1'b1;
          end
        end
        default: fill_state <= FILL_IDLE;
      endcase

      // PC update and branch stall
      if (npc_valid_i) begin
        pc_q           <= npc_i;
        branch_stall_q <= 1'b0;
      end else if (emit) begin
        if (is_ctrl) begin
          branch_stall_q <= 1'b1;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
        if (is_fence_i) begin
          line_valid <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ifu_rvalid_i && fill_state == FILL_EVEN_REQ) begin
      line_data[pc_idx][0] <= ifu_rdata_i;
      line_tag[pc_idx]     <= pc_tag;
    end
    if (ifu_rvalid_i && fill_state == FILL_ODD_REQ) begin
      line_data[pc_idx][1] <= ifu_rdata_i;
    end
  end

  // Request stays up with the same address until the memory answers
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    ifu_arvalid_o && !ifu_rvalid_i |=> ifu_arvalid_o && $stable(ifu_araddr_o));

  a_no_fetch_during_fill: assert property (@(posedge clk) disable iff (rst)
    fill_state != FILL_IDLE |-> !fetch_valid_o);

endmodule

`default_nettype wire

//--- rtl/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue (
  input  wire                          clk,
  input  wire                          rst,
  // Enqueue side
  input  wire  [ifetch_pkg::XLEN-1:0]  enq_pc_i,
  input  wire  [ifetch_pkg::XLEN-1:0]  enq_inst_i,
  input  wire                          enq_valid_i,
  output logic                         enq_ready_o,
  // Dequeue side
  output logic [ifetch_pkg::XLEN-1:0]  deq_pc_o,
  output logic [ifetch_pkg::XLEN-1:0]  deq_inst_o,
  output logic                         deq_valid_o,
  input  wire                          deq_ready_i
);
  import ifetch_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W+1)'(QUEUE_DEPTH);

  fetch_entry_t entries [QUEUE_DEPTH];
  fetch_entry_t head;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0] count;
  logic push;
  logic pop;

  assign enq_ready_o = (count != FULL_COUNT);
  assign deq_valid_o = (count != '0);

  assign push = enq_valid_i && enq_ready_o;
  assign pop  = deq_valid_o && deq_ready_i;

  assign head       = entries[rd_ptr];
  assign deq_pc_o   = head.pc;
  assign deq_inst_o = head.inst;

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= '{pc: enq_pc_i, inst: enq_inst_i};
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer keeps its entry steady until there is room
  a_no_enq_full: assert property (@(posedge clk) disable iff (rst)
    enq_valid_i && !enq_ready_o |=>
      enq_valid_i && $stable(enq_pc_i) && $stable(enq_inst_i));

  a_no_deq_empty: assert property (@(posedge clk) disable iff (rst)
    !deq_valid_o |-> (rd_ptr == wr_ptr));

endmodule

`default_nettype wire

//--- rtl/retire_unit.sv
`timescale 1ns/1ps
`default_nettype none

module retire_unit (
  input  wire                          clk,
  input  wire                          rst,
  // From instruction queue
  input  wire  [ifetch_pkg::XLEN-1:0]  deq_pc_i,
  input  wire  [ifetch_pkg::XLEN-1:0]  deq_inst_i,
  input  wire                          deq_valid_i,
  output logic                         deq_ready_o,
  input  wire                          hold_i,
  // Resolved next PC to fetch
  output logic [ifetch_pkg::XLEN-1:0]  npc_o,
  output logic                         npc_valid_o,
  // Retirement report
  output logic [ifetch_pkg::XLEN-1:0]  retire_pc_o,
  output logic [ifetch_pkg::XLEN-1:0]  retire_inst_o,
  output logic                         retire_valid_o
);
  import ifetch_pkg::*;

  logic [XLEN-1:0] xreg [1:7];   // x0 reads as zero

  logic accept;
  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [2:0] funct3;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] wr_data;
  logic wr_en;
  logic is_ctrl;

  assign deq_ready_o = !hold_i;
  assign accept      = deq_valid_i && deq_ready_o;

  assign opcode = deq_inst_i[6:0];
  assign rd     = deq_inst_i[11:7];
  assign funct3 = deq_inst_i[14:12];
  assign rs1    = deq_inst_i[19:15];
  assign rs2    = deq_inst_i[24:20];

  assign rs1_val = (rs1 != '0 && rs1[4:3] == 2'b00) ? xreg[rs1[2:0]] : '0;
  assign rs2_val = (rs2 != '0 && rs2[4:3] == 2'b00) ? xreg[rs2[2:0]] : '0;

  assign imm_i = {{20{deq_inst_i[31]}}, deq_inst_i[31:20]};
  assign imm_u = {deq_inst_i[31:12], 12'b0};
  assign imm_b = {{19{deq_inst_i[31]}}, deq_inst_i[31], deq_inst_i[7],
                  deq_inst_i[30:25], deq_inst_i[11:8], 1'b0};
  assign imm_j = {{11{deq_inst_i[31]}}, deq_inst_i[31], deq_inst_i[19:12],
                  deq_inst_i[20], deq_inst_i[30:21], 1'b0};

  assign pc_plus4 = deq_pc_i + 32'd4;

  // ***********************************************************
  // Decode and next PC
  // ***********************************************************

  always_comb begin
    wr_en   = 1'b0;
    wr_data = '0;
    next_pc = pc_plus4;
    is_ctrl = 1'b0;
    case (opcode)
      OP_LUI: begin
        wr_en   = 1'b1;
        wr_data = imm_u;
      end
      OP_OP_IMM: begin
        wr_en   = (funct3 == 3'b000);   // ADDI only
        wr_data = rs1_val + imm_i;
      end
      OP_JAL: begin
        is_ctrl = 1'b1;
        wr_en   = 1'b1;
        wr_data = pc_plus4;
        next_pc = deq_pc_i + imm_j;
      end
      OP_JALR: begin
        is_ctrl = 1'b1;
        wr_en   = 1'b1;
        wr_data = pc_plus4;
        next_pc = (rs1_val + imm_i) & ~32'd1;
      end
      OP_BRANCH: begin
        is_ctrl = 1'b1;
        if ((funct3 == 3'b000 && rs1_val == rs2_val) ||
            (funct3 == 3'b001 && rs1_val != rs2_val)) begin
          next_pc = deq_pc_i + imm_b;
        end
      end
      OP_MISC_MEM, OP_SYSTEM: begin
        wr_en = 1'b0;   // fence.i is handled in the fetch unit
      end
      default: wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 8; i++) begin
        xreg[i] <= '0;
      end
    end else if (accept && wr_en && rd != '0 && rd[4:3] == 2'b00) begin
      xreg[rd[2:0]] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid_o <= 1'b0;
      npc_valid_o    <= 1'b0;
    end else begin
      retire_valid_o <= accept;
      npc_valid_o    <= accept && is_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      retire_pc_o   <= deq_pc_i;
      retire_inst_o <= deq_inst_i;
      npc_o         <= next_pc;
    end
  end

  // Fetch stalls on control flow, so nothing follows until npc is back
  a_no_accept_npc_pending: assert property (@(posedge clk) disable iff (rst)
    accept && is_ctrl |=> !accept);

endmodule

`default_nettype wire

//--- rtl/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_top (
  input  wire                          clk,
  input  wire                          rst,
  output logic [ifetch_pkg::XLEN-1:0]  ifu_araddr_o,
  output logic                         ifu_arvalid_o,
  input  wire  [ifetch_pkg::XLEN-1:0]  ifu_rdata_i,
  input  wire                          ifu_rvalid_i,
  input  wire                          hold_i,
  output logic [ifetch_pkg::XLEN-1:0]  retire_pc_o,
  output logic [ifetch_pkg::XLEN-1:0]  retire_inst_o,
  output logic                         retire_valid_o
);
  import ifetch_pkg::*;

  logic [XLEN-1:0] fetch_pc;
  logic [XLEN-1:0] fetch_inst;
  logic fetch_valid;
  logic enq_ready;
  logic [XLEN-1:0] deq_pc;
  logic [XLEN-1:0] deq_inst;
  logic deq_valid;
  logic deq_ready;
  logic [XLEN-1:0] npc;
  logic npc_valid;

  icache_fetch icache_fetch_inst (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_o  (ifu_araddr_o),
    .ifu_arvalid_o (ifu_arvalid_o),
    .ifu_rdata_i   (ifu_rdata_i),
    .ifu_rvalid_i  (ifu_rvalid_i),
    .npc_i         (npc),
    .npc_valid_i   (npc_valid),
    .fetch_pc_o    (fetch_pc),
    .fetch_inst_o  (fetch_inst),
    .fetch_valid_o (fetch_valid),
    .enq_ready_i   (enq_ready)
  );

  inst_queue inst_queue_inst (
    .clk         (clk),
    .rst         (rst),
    .enq_pc_i    (fetch_pc),
    .enq_inst_i  (fetch_inst),
    .enq_valid_i (fetch_valid),
    .enq_ready_o (enq_ready),
    .deq_pc_o    (deq_pc),
    .deq_inst_o  (deq_inst),
    .deq_valid_o (deq_valid),
    .deq_ready_i (deq_ready)
  );

  retire_unit retire_unit_inst (
    .clk            (clk),
    .rst            (rst),
    .deq_pc_i       (deq_pc),
    .deq_inst_i     (deq_inst),
    .deq_valid_i    (deq_valid),
    .deq_ready_o    (deq_ready),
    .hold_i         (hold_i),
    .npc_o          (npc),
    .npc_valid_o    (npc_valid),
    .retire_pc_o    (retire_pc_o),
    .retire_inst_o  (retire_inst_o),
    .retire_valid_o (retire_valid_o)
  );

endmodule

`default_nettype wire

//--- tb/imem_model.sv
`timescale 1ns/1ps
`default_nettype none

module imem_model (
  input  wire                          clk,
  input  wire                          rst,
  input  wire  [ifetch_pkg::XLEN-1:0]  araddr_i,
  input  wire                          arvalid_i,
  output logic [ifetch_pkg::XLEN-1:0]  rdata_o,
  output logic                         rvalid_o
);
  import ifetch_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int LATENCY   = 3;

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [7:0] addr_q;   // Word index, upper address bits alias
  logic busy;
  int wait_cnt;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {24'hDEAD00, i[7:0]};
    end
    $readmemh("tb/program.hex", mem);
    busy     = 1'b0;
    wait_cnt = 0;
    addr_q   = '0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
  end

  // Request is sampled once the DUT has settled after the edge
  always @(posedge clk) begin
    #1;
    rvalid_o = 1'b0;
    if (rst) begin
      busy = 1'b0;
    end else if (busy) begin
      wait_cnt = wait_cnt + 1;
      if (wait_cnt == LATENCY) begin
        rvalid_o = 1'b1;   // One cycle pulse
        rdata_o  = mem[addr_q];
        busy     = 1'b0;
      end
    end else if (arvalid_i) begin
      busy     = 1'b1;
      wait_cnt = 0;
      addr_q   = araddr_i[9:2];
    end
  end

endmodule

`default_nettype wire

//--- tb/ifetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb;
  import ifetch_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int TIMEOUT      = 2000;
  localparam int HOLD_CYCLES  = 300;
  localparam int MODEL_STEPS  = 128;
  localparam int RUN_TARGET   = 24;   // A few turns of the closing self loop
  localparam int STRAIGHT_END = 4;    // Retirement indices in program order
  localparam int LOOP_END     = 13;
  localparam logic [XLEN-1:0] LOOP_FIRST = 32'h0000_0010;
  localparam logic [XLEN-1:0] LOOP_LAST  = 32'h0000_0018;
  localparam logic [XLEN-1:0] WRONG_PATH = 32'h7FF0_0313;   // addi x6, x0, 2047

  logic clk;
  logic rst;
  logic hold;
  logic [XLEN-1:0] ifu_araddr;
  logic ifu_arvalid;
  logic [XLEN-1:0] ifu_rdata;
  logic ifu_rvalid;
  logic [XLEN-1:0] retire_pc;
  logic [XLEN-1:0] retire_inst;
  logic retire_valid;

  logic [XLEN-1:0] prog [256];
  logic [XLEN-1:0] exp_pc [$];
  logic [XLEN-1:0] exp_inst [$];
  logic [XLEN-1:0] ret_pc [$];
  logic [XLEN-1:0] ret_inst [$];
  logic [XLEN-1:0] rd_addr [$];
  int rd_ret [$];   // Retirements already seen when the read completed
  int checks;
  int errors;
  bit timed_out;

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ifetch_top ifetch_top_inst (
    .clk            (clk),
    .rst            (rst),
    .ifu_araddr_o   (ifu_araddr),
    .ifu_arvalid_o  (ifu_arvalid),
    .ifu_rdata_i    (ifu_rdata),
    .ifu_rvalid_i   (ifu_rvalid),
    .hold_i         (hold),
    .retire_pc_o    (retire_pc),
    .retire_inst_o  (retire_inst),
    .retire_valid_o (retire_valid)
  );

  imem_model imem_model_inst (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (ifu_araddr),
    .arvalid_i (ifu_arvalid),
    .rdata_o   (ifu_rdata),
    .rvalid_o  (ifu_rvalid)
  );

  // Mid-cycle monitor for retirements and completed bus reads
  always @(negedge clk) begin
    if (!rst && retire_valid) begin
      ret_pc.push_back(retire_pc);
      ret_inst.push_back(retire_inst);
    end
    if (!rst && ifu_arvalid && ifu_rvalid) begin
      rd_addr.push_back(ifu_araddr);
      rd_ret.push_back(ret_pc.size());
    end
  end

  // ***********************************************************
  // Reference ISA model over the program image
  // ***********************************************************

  task automatic build_model();
    logic [XLEN-1:0] regs [8];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] next;
    logic [XLEN-1:0] wdata;
    bit wr;
    for (int r = 0; r < 8; r++) begin
      regs[r] = '0;
    end
    pc = PC_INIT;
    for (int n = 0; n < MODEL_STEPS; n++) begin
      inst = prog[pc[9:2]];
      exp_pc.push_back(pc);
      exp_inst.push_back(inst);
      a     = (inst[19:18] == 2'b00) ? regs[inst[17:15]] : '0;   // Only x0..x7 exist
      b     = (inst[24:23] == 2'b00) ? regs[inst[22:20]] : '0;
      next  = pc + 32'd4;
      wr    = 1'b0;
      wdata = '0;
      case (inst[6:0])
        OP_LUI: begin
          wr    = 1'b1;
          wdata = {inst[31:12], 12'h000};
        end
        OP_OP_IMM: begin
          wr    = (inst[14:12] == 3'b000);
          wdata = a + {{20{inst[31]}}, inst[31:20]};
        end
        OP_JAL: begin
          wr    = 1'b1;
          wdata = pc + 32'd4;
          next  = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        OP_JALR: begin
          wr    = 1'b1;
          wdata = pc + 32'd4;
          next  = (a + {{20{inst[31]}}, inst[31:20]}) & 32'hFFFF_FFFE;
        end
        OP_BRANCH: begin
          if ((inst[14:12] == 3'b000 && a == b) || (inst[14:12] == 3'b001 && a != b)) begin
            next = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
          end
        end
        default: wr = 1'b0;
      endcase
      if (wr && inst[11:10] == 2'b00 && inst[9:7] != 3'b000) begin
        regs[inst[9:7]] = wdata;
      end
      pc = next;
    end
  endtask

  // ***********************************************************
  // Compare tasks
  // ***********************************************************

  task automatic check_pc(input string name, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_inst(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_range(input int first, input int last);
    if (ret_pc.size() < last) begin
      errors++;
      $display("only %0d instructions retired, %0d expected", ret_pc.size(), last);
    end else begin
      for (int i = first; i < last; i++) begin
        check_pc($sformatf("retire_pc_o[%0d]", i), ret_pc[i], exp_pc[i]);
        check_inst($sformatf("retire_inst_o[%0d]", i), ret_inst[i], exp_inst[i]);
      end
    end
  endtask

  function automatic int count_reads(input logic [XLEN-1:0] addr, input int after);
    int n;
    n = 0;
    foreach (rd_addr[i]) begin
      if (rd_addr[i] == addr && rd_ret[i] > after) begin
        n++;
      end
    end
    return n;
  endfunction

  // Reset, then run until enough retirements, with hold optionally random
  task automatic run_program(input bit random_hold);
    int cycles;
    logic [31:0] rnd;
    @(posedge clk);
    #2;
    rst  = 1'b1;
    hold = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    ret_pc.delete();
    ret_inst.delete();
    rd_addr.delete();
    rd_ret.delete();
    rst    = 1'b0;
    cycles = 0;
    while (ret_pc.size() < RUN_TARGET || (random_hold && cycles < HOLD_CYCLES)) begin
      @(posedge clk);
      #2;
      rnd  = $urandom;
      hold = random_hold && cycles < HOLD_CYCLES && rnd[0];
      cycles++;
      if (cycles >= TIMEOUT) begin
        timed_out = 1'b1;
        errors++;
        $display("timeout after %0d cycles with %0d instructions retired", cycles,
                 ret_pc.size());
        break;
      end
    end
    hold = 1'b0;
  endtask

  // ***********************************************************
  // Directed tests
  // ***********************************************************

  task automatic test_straight();
    run_program(1'b0);
    if (!timed_out) begin
      compare_range(0, STRAIGHT_END);
    end
  endtask

  task automatic test_loop();
    int got_iter;
    int exp_iter;
    logic [XLEN-1:0] addr;
    run_program(1'b0);
    if (timed_out) begin
      return;
    end
    compare_range(STRAIGHT_END, LOOP_END);
    got_iter = 0;
    exp_iter = 0;
    for (int i = 0; i < LOOP_END; i++) begin
      if (exp_pc[i] == LOOP_LAST) begin
        exp_iter++;
      end
      if (i < ret_pc.size() && ret_pc[i] == LOOP_LAST) begin
        got_iter++;
      end
    end
    check_count("loop iterations", got_iter, exp_iter);
    // Later iterations must hit in the cache
    addr = LOOP_FIRST;
    while (addr <= LOOP_LAST) begin
      check_count($sformatf("bus reads of 0x%08h", addr), count_reads(addr, -1), 1);
      addr = addr + 32'd4;
    end
  endtask

  task automatic test_jump();
    run_program(1'b0);
    if (timed_out) begin
      return;
    end
    compare_range(LOOP_END, RUN_TARGET);
    foreach (ret_inst[i]) begin
      checks++;
      if (ret_inst[i] == WRONG_PATH) begin
        errors++;
        $display("wrong-path instruction retired at pc 0x%08h", ret_pc[i]);
      end
    end
  endtask

  task automatic test_hold();
    run_program(1'b1);
    if (timed_out) begin
      return;
    end
    if (ret_pc.size() > MODEL_STEPS) begin
      errors++;
      $display("more instructions retired than the reference model produced");
    end else begin
      compare_range(0, ret_pc.size());
    end
  endtask

  task automatic test_fence_i();
    int fence_idx;
    logic [XLEN-1:0] line;
    run_program(1'b0);
    if (timed_out) begin
      return;
    end
    fence_idx = -1;
    for (int i = 0; i < RUN_TARGET; i++) begin
      if (fence_idx < 0 && exp_inst[i] == INST_FENCE_I) begin
        fence_idx = i;
      end
    end
    if (fence_idx < 0) begin
      errors++;
      $display("program reaches no fence.i within the run");
      return;
    end
    line = exp_pc[fence_idx] & ~32'(L1I_WORDS * 4 - 1);
    check_count("bus reads of fence.i line", count_reads(line, -1), 2);
    check_count("bus reads of fence.i line after retire", count_reads(line, fence_idx), 1);
  endtask

  initial begin
    rst       = 1'b1;
    hold      = 1'b0;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    void'($urandom(29));
    $readmemh("tb/program.hex", prog);
    build_model();
    test_straight();
    test_loop();
    test_jump();
    test_hold();
    test_fence_i();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ifetch.f
rtl/ifetch_pkg.sv
rtl/icache_fetch.sv
rtl/inst_queue.sv
rtl/retire_unit.sv
rtl/ifetch_top.sv
tb/imem_model.sv
tb/ifetch_tb.sv

//--- Makefile
# Verilator build of the ifetch testbench

SIM = obj_dir/Vifetch_tb

$(SIM): ifetch.f $(wildcard rtl/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module ifetch_tb -f ifetch.f -o Vifetch_tb

.PHONY: run clean

run: $(SIM) tb/program.hex
	./$(SIM) | tee sim.log
	grep -qx "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/program.hex
// One 32-bit instruction word per line, word 0 at byte address 0x00
// Comment columns: byte address, assembly
00500093  // 00: addi x1, x0, 5
12345137  // 04: lui  x2, 0x12345
67810113  // 08: addi x2, x2, 0x678
00300193  // 0c: addi x3, x0, 3
00120213  // 10: addi x4, x4, 1      loop body
fff18193  // 14: addi x3, x3, -1
fe019ce3  // 18: bne  x3, x0, -8
00c002ef  // 1c: jal  x5, +12
7ff00313  // 20: addi x6, x0, 2047   never retired
7ff00313  // 24: addi x6, x0, 2047   never retired
011283e7  // 28: jalr x7, 17(x5)     target 0x30, low bit cleared
7ff00313  // 2c: addi x6, x0, 2047   never retired
0000100f  // 30: fence.i
00438313  // 34: addi x6, x7, 4
00108463  // 38: beq  x1, x1, +8
7ff00313  // 3c: addi x6, x0, 2047   never retired
0000006f  // 40: jal  x0, 0          park here
